// File: all.f
verilog/uart_pkg.sv
verilog/cmd_splitter.sv
verilog/frame_tx.sv
verilog/frame_rx.sv
verilog/uart_bridge.sv
sim/uart_bridge_assert.sv
sim/tb_uart_bridge.sv

// File: Bender.yml
package:
  name: uart_bridge

sources:
  - verilog/uart_pkg.sv
  - verilog/cmd_splitter.sv
  - verilog/frame_tx.sv
  - verilog/frame_rx.sv
  - verilog/uart_bridge.sv
  - target: simulation
    files:
      - sim/uart_bridge_assert.sv
      - sim/tb_uart_bridge.sv

// File: sim/tb_uart_bridge.sv
`timescale 1ns/1ps

module tb_uart_bridge;

  logic        clk;
  logic        rst_n;
  logic [15:0] cmd_in;
  logic        cmd_vld;
  logic        cmd_rdy;
  logic        rx;
  logic        rx_drv;
  logic        loopback;
  logic        tx;
  logic        read_rdy;
  logic [8:0]  read_data;
  logic [7:0]  tx_q[$];   // bytes seen on tx
  logic [8:0]  rd_q[$];   // read words
  string       test_name;
  int          seed;
  int          cycle_cnt;

  assign rx = loopback ? tx : rx_drv;

  uart_bridge UUT (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // about 60 frames of 176 cycles, plus margin
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < 20_000) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: the run hung after %0d cycles", cycle_cnt);
    end_with_failure();
  end

  always @(negedge clk) begin
    if (rst_n && read_rdy === 1'b1) begin
      rd_q.push_back(read_data);
    end
  end

  initial begin : tx_monitor
    logic [7:0] tx_byte;
    forever begin
      recv_frame(tx_byte);
      tx_q.push_back(tx_byte);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // checking and line models

  task automatic end_with_failure();
    $display("=== FAIL ===");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_val(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (expected !== actual) begin
      $display("[FAIL] %s: expected %0h, actual %0h", name, expected, actual);
      end_with_failure();
    end
  endtask

  // samples at mid-bit, on the falling clock
  task automatic recv_frame(output logic [7:0] data);
    logic [10:0] bits;
    int          i;
    @(negedge clk);
    while (tx !== 1'b0) @(negedge clk);
    repeat (uart_pkg::HALF_DIV - 1) @(negedge clk);
    for (i = 0; i < uart_pkg::FRAME_BITS; i++) begin
      bits[i] = tx;
      if (i < uart_pkg::FRAME_BITS - 1) begin
        repeat (uart_pkg::BAUD_DIV) @(negedge clk);
      end
    end
    check_val({test_name, ": tx start bit"}, 0, bits[0]);
    check_val({test_name, ": tx odd parity"}, 1, $countones(bits[9:1]) % 2);
    check_val({test_name, ": tx stop bit"}, 1, bits[10]);
    data = bits[8:1];
  endtask

  task automatic send_frame(input logic [7:0] data, input logic bad_par,
                            input logic stop_bit);
    logic [10:0] bits;
    logic        par;
    int          i;
    par  = ($countones(data) % 2 == 0) ^ bad_par;  // odd ones over data and parity
    bits = {stop_bit, par, data, 1'b0};
    for (i = 0; i < uart_pkg::FRAME_BITS; i++) begin
      @(posedge clk);
      #1;
      rx_drv = bits[i];
      repeat (uart_pkg::BAUD_DIV - 1) @(posedge clk);
    end
    @(posedge clk);
    #1;
    rx_drv = 1'b1;
  endtask

  task automatic wait_cmd_rdy();
    int waited;
    waited = 0;
    @(negedge clk);
    while (cmd_rdy !== 1'b1 && waited < 3 * uart_pkg::FRAME_BITS * uart_pkg::BAUD_DIV) begin
      @(negedge clk);
      waited++;
    end
    if (cmd_rdy !== 1'b1) begin
      $display("%s: cmd_rdy never came back", test_name);
      end_with_failure();
    end
  endtask

  task automatic wait_queues(input int n_tx, input int n_rd);
    int waited;
    waited = 0;
    while ((tx_q.size() < n_tx || rd_q.size() < n_rd) &&
           waited < 3 * uart_pkg::FRAME_BITS * uart_pkg::BAUD_DIV) begin
      @(negedge clk);
      waited++;
    end
    if (tx_q.size() < n_tx || rd_q.size() < n_rd) begin
      $display("%s: timed out waiting for tx frames or read words", test_name);
      end_with_failure();
    end
  endtask

  task automatic send_cmd(input logic [15:0] cmd);
    @(posedge clk);
    #1;
    cmd_in  = cmd;
    cmd_vld = 1'b1;
    wait_cmd_rdy();  // rdy high here, taken on the next edge
    @(posedge clk);
    #1;
    cmd_vld = 1'b0;
    cmd_in  = ~cmd;
    check_val({test_name, ": cmd_rdy after accept"}, 0, cmd_rdy);
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests

  task automatic reset_state_holds();
    test_name = "reset_state";
    repeat (20) begin
      @(negedge clk);
      check_val({test_name, ": tx"}, 1, tx);
      check_val({test_name, ": cmd_rdy"}, 1, cmd_rdy);
      check_val({test_name, ": read_rdy"}, 0, read_rdy);
    end
  endtask

  task automatic single_cmd_frames();
    test_name = "single_cmd";
    tx_q.delete();
    send_cmd(16'hA55A);
    wait_queues(1, 0);
    check_val({test_name, ": cmd_rdy mid transfer"}, 0, cmd_rdy);
    wait_queues(2, 0);
    wait_cmd_rdy();
    check_val({test_name, ": high byte"}, 8'hA5, tx_q[0]);
    check_val({test_name, ": low byte"}, 8'h5A, tx_q[1]);
  endtask

  task automatic back_to_back_cmds();
    logic [31:0] both;
    int          i;
    test_name = "back_to_back";
    both      = {16'h1234, 16'hBEEF};
    tx_q.delete();
    send_cmd(both[31:16]);
    send_cmd(both[15:0]);
    wait_queues(4, 0);
    repeat (uart_pkg::FRAME_BITS * uart_pkg::BAUD_DIV) @(negedge clk);
    check_val({test_name, ": byte count"}, 4, tx_q.size());
    for (i = 0; i < 4; i++) begin
      check_val({test_name, ": byte order"}, both[31 - 8 * i -: 8], tx_q[i]);
    end
  endtask

  task automatic rx_parity_flag();
    test_name = "rx_parity";
    rd_q.delete();
    send_frame(8'h3C, 1'b0, 1'b1);
    wait_queues(0, 1);
    check_val({test_name, ": good parity"}, 9'h03C, rd_q[0]);
    send_frame(8'h3C, 1'b1, 1'b1);
    wait_queues(0, 2);
    check_val({test_name, ": bad parity"}, 9'h13C, rd_q[1]);
    check_val({test_name, ": word count"}, 2, rd_q.size());
  endtask

  task automatic rx_bad_stop_dropped();
    test_name = "rx_bad_stop";
    rd_q.delete();
    send_frame(8'h96, 1'b0, 1'b0);
    repeat (uart_pkg::FRAME_BITS * uart_pkg::BAUD_DIV) @(negedge clk);
    check_val({test_name, ": dropped frame"}, 0, rd_q.size());
    send_frame(8'hC3, 1'b0, 1'b1);
    wait_queues(0, 1);
    check_val({test_name, ": next frame"}, 9'h0C3, rd_q[0]);
  endtask

  task automatic loopback_random();
    logic [31:0] rnd;
    test_name = "loopback";
    loopback  = 1'b1;
    repeat (10) begin
      rd_q.delete();
      rnd = $random(seed);
      send_cmd(rnd[15:0]);
      wait_queues(0, 2);
      check_val({test_name, ": high word"}, {1'b0, rnd[15:8]}, rd_q[0]);
      check_val({test_name, ": low word"}, {1'b0, rnd[7:0]}, rd_q[1]);
    end
  endtask

  initial begin
    rst_n     = 1'b0;
    cmd_in    = '0;
    cmd_vld   = 1'b0;
    rx_drv    = 1'b1;  // idle line
    loopback  = 1'b0;
    seed      = 32'h431d_108f;
    test_name = "reset";
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    reset_state_holds();
    single_cmd_frames();
    back_to_back_cmds();
    rx_parity_flag();
    rx_bad_stop_dropped();
    loopback_random();
    if (UUT.u_assert.fail_cnt == 0) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      $display("%0d assertion failures on the bridge", UUT.u_assert.fail_cnt);
      end_with_failure();
    end
  end

endmodule

// File: sim/uart_bridge_assert.sv
`timescale 1ns/1ps

module uart_bridge_assert (
  input logic                            clk,
  input logic                            rst_n,
  input logic                            byte_req,
  input logic                            byte_ack,
  input logic [uart_pkg::READ_WIDTH-1:0] byte_data,
  input logic                            tx,
  input logic                            read_rdy
);

  int fail_cnt = 0;

  // four-phase: new request only once ack has dropped
  req_rise_ack_low: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(byte_req) |-> !byte_ack)
    else begin
      fail_cnt++;
      $error("byte_req rose while byte_ack was still high");
    end

  req_data_stable: assert property (@(posedge clk) disable iff (!rst_n)
    byte_req && $past(byte_req) |-> byte_data == $past(byte_data))
    else begin
      fail_cnt++;
      $error("byte_data changed while byte_req was held");
    end

  read_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    read_rdy |=> !read_rdy)
    else begin
      fail_cnt++;
      $error("read_rdy high for two cycles in a row");
    end

  // ack low only while frame_tx sits idle
  tx_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
    !byte_ack |-> tx)
    else begin
      fail_cnt++;
      $error("tx low while the transmitter is idle");
    end

endmodule

bind uart_bridge uart_bridge_assert u_assert (.*);

// File: verilog/uart_bridge.sv
`timescale 1ns/1ps

module uart_bridge (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic [uart_pkg::CMD_WIDTH-1:0]  cmd_in,
  input  logic                            cmd_vld,
  output logic                            cmd_rdy,
  input  logic                            rx,
  output logic                            tx,
  output logic                            read_rdy,
  output logic [uart_pkg::READ_WIDTH:0]   read_data
);

  // splitter to transmitter, four-phase
  logic                            byte_req;
  logic                            byte_ack;
  logic [uart_pkg::READ_WIDTH-1:0] byte_data;

  cmd_splitter u_splitter (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .byte_req  (byte_req),
    .byte_ack  (byte_ack),
    .byte_data (byte_data)
  );

  frame_tx u_tx (
    .clk       (clk),
    .rst_n     (rst_n),
    .byte_req  (byte_req),
    .byte_ack  (byte_ack),
    .byte_data (byte_data),
    .tx        (tx)
  );

  frame_rx u_rx (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .read_rdy  (read_rdy),
    .read_data (read_data)
  );

endmodule

// File: verilog/frame_rx.sv
`timescale 1ns/1ps

module frame_rx (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          rx,
  output logic                          read_rdy,
  output logic [uart_pkg::READ_WIDTH:0] read_data
);

  logic                            rx_s1;
  logic                            rx_s2;
  logic                            rx_d;
  logic [1:0]                      state;
  logic [uart_pkg::BAUD_CNT_W-1:0] baud_cnt;
  logic [uart_pkg::BIT_CNT_W-1:0]  bit_cnt;
  logic [uart_pkg::READ_WIDTH:0]   rx_shift;  // parity above data
  logic                            start_edge;
  logic                            half_hit;
  logic                            bit_hit;
  logic                            stop_slot;
  logic                            parity_err;

  assign start_edge = rx_d & ~rx_s2;
  assign half_hit   = baud_cnt == (uart_pkg::BAUD_CNT_W)'(uart_pkg::HALF_DIV - 1);
  assign bit_hit    = baud_cnt == (uart_pkg::BAUD_CNT_W)'(uart_pkg::BAUD_DIV - 1);
  assign stop_slot  = bit_cnt == (uart_pkg::BIT_CNT_W)'(uart_pkg::READ_WIDTH + 1);
  assign parity_err = ~^rx_shift;  // odd count of ones is good

  // two-flop sync plus edge history, line idles high
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_s1 <= 1'b1;
      rx_s2 <= 1'b1;
      rx_d  <= 1'b1;
    end else begin
      rx_s1 <= rx;
      rx_s2 <= rx_s1;
      rx_d  <= rx_s2;
    end
  end

  always_ff @(posedge clk) begin
    if (state == uart_pkg::RX_DATA && bit_hit && !stop_slot) begin
      rx_shift <= {rx_s2, rx_shift[uart_pkg::READ_WIDTH:1]};  // lsb arrives first
    end
  end

  always_ff @(posedge clk) begin
    if (state == uart_pkg::RX_DATA && bit_hit && stop_slot && rx_s2) begin
      read_data <= {parity_err, rx_shift[uart_pkg::READ_WIDTH-1:0]};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // frame sampling

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= uart_pkg::RX_IDLE;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      read_rdy <= 1'b0;
    end else begin
      read_rdy <= 1'b0;
      case (state)
        uart_pkg::RX_IDLE: begin
          if (start_edge) begin
            baud_cnt <= '0;
            state    <= uart_pkg::RX_START;
          end
        end
        uart_pkg::RX_START: begin
          if (half_hit) begin
            baud_cnt <= '0;
            bit_cnt  <= '0;
            // glitch if the line is back high
            state    <= rx_s2 ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        uart_pkg::RX_DATA: begin
          if (bit_hit) begin
            baud_cnt <= '0;
            if (stop_slot) begin
              read_rdy <= rx_s2;  // low stop drops the frame
              state    <= uart_pkg::RX_IDLE;
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
            end
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        default: state <= uart_pkg::RX_IDLE;
      endcase
    end
  end

endmodule

// File: verilog/frame_tx.sv
`timescale 1ns/1ps

module frame_tx (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            byte_req,
  output logic                            byte_ack,
  input  logic [uart_pkg::READ_WIDTH-1:0] byte_data,
  output logic                            tx
);

  logic [1:0]                        state;
  logic [uart_pkg::READ_WIDTH-1:0]   data_q;
  logic [uart_pkg::FRAME_BITS-1:0]   shift_q;
  logic [uart_pkg::BAUD_CNT_W-1:0]   baud_cnt;
  logic [uart_pkg::BIT_CNT_W-1:0]    bit_cnt;
  logic                              baud_last;
  logic                              frame_end;

  assign baud_last = baud_cnt == (uart_pkg::BAUD_CNT_W)'(uart_pkg::BAUD_DIV - 1);
  assign frame_end = bit_cnt == (uart_pkg::BIT_CNT_W)'(uart_pkg::FRAME_BITS);

  always_ff @(posedge clk) begin
    if (state == uart_pkg::TX_IDLE && byte_req && !byte_ack) begin
      data_q <= byte_data;
    end
  end

  // frame word, sent lsb first
  always_ff @(posedge clk) begin
    if (state == uart_pkg::TX_LOAD) begin
      shift_q <= {1'b1, ~^data_q, data_q, 1'b0};  // stop, odd parity, data, start
    end else if (state == uart_pkg::TX_SEND && baud_cnt == '0) begin
      shift_q <= {1'b1, shift_q[uart_pkg::FRAME_BITS-1:1]};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // bit timing

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= uart_pkg::TX_IDLE;
      byte_ack <= 1'b0;
      tx       <= 1'b1;
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end else begin
      case (state)
        uart_pkg::TX_IDLE: begin
          if (byte_req && !byte_ack) begin
            byte_ack <= 1'b1;
            state    <= uart_pkg::TX_LOAD;
          end
        end
        uart_pkg::TX_LOAD: begin
          baud_cnt <= '0;
          bit_cnt  <= '0;
          state    <= uart_pkg::TX_SEND;
        end
        uart_pkg::TX_SEND: begin
          if (baud_cnt == '0 && frame_end) begin
            // stop bit has run its full length
            if (byte_req) begin
              state <= uart_pkg::TX_HOLD;
            end else begin
              byte_ack <= 1'b0;
              state    <= uart_pkg::TX_IDLE;
            end
          end else begin
            if (baud_cnt == '0) begin
              tx <= shift_q[0];  // next bit onto the line
            end
            if (baud_last) begin
              baud_cnt <= '0;
              bit_cnt  <= bit_cnt + 1'b1;
            end else begin
              baud_cnt <= baud_cnt + 1'b1;
            end
          end
        end
        uart_pkg::TX_HOLD: begin
          if (!byte_req) begin
            byte_ack <= 1'b0;
            state    <= uart_pkg::TX_IDLE;
          end
        end
        default: state <= uart_pkg::TX_IDLE;
      endcase
    end
  end

endmodule

// File: verilog/cmd_splitter.sv
`timescale 1ns/1ps

module cmd_splitter (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic [uart_pkg::CMD_WIDTH-1:0]  cmd_in,
  input  logic                            cmd_vld,
  output logic                            cmd_rdy,
  output logic                            byte_req,
  input  logic                            byte_ack,
  output logic [uart_pkg::READ_WIDTH-1:0] byte_data
);

  logic [2:0]          state;
  uart_pkg::cmd_word_u cmd_q;
  logic                lo_phase;

  // held command, host may move on
  always_ff @(posedge clk) begin
    if (cmd_vld && cmd_rdy) begin
      cmd_q.raw <= cmd_in;
    end
  end

  assign lo_phase  = (state == uart_pkg::SPL_SEND_LO) || (state == uart_pkg::SPL_WAIT_LO);
  assign byte_data = lo_phase ? cmd_q.bytes.lo : cmd_q.bytes.hi;

  //////////////////////////////////////////////////////////////////////
  // four-phase sequencing, high byte first

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= uart_pkg::SPL_IDLE;
      cmd_rdy  <= 1'b1;
      byte_req <= 1'b0;
    end else begin
      case (state)
        uart_pkg::SPL_IDLE: begin
          if (cmd_vld && cmd_rdy) begin
            cmd_rdy  <= 1'b0;
            byte_req <= 1'b1;
            state    <= uart_pkg::SPL_SEND_HI;
          end
        end
        uart_pkg::SPL_SEND_HI: begin
          if (byte_ack) begin
            byte_req <= 1'b0;
            state    <= uart_pkg::SPL_WAIT_HI;
          end
        end
        uart_pkg::SPL_WAIT_HI: begin
          if (!byte_ack) begin  // high frame fully out
            byte_req <= 1'b1;
            state    <= uart_pkg::SPL_SEND_LO;
          end
        end
        uart_pkg::SPL_SEND_LO: begin
          if (byte_ack) begin
            byte_req <= 1'b0;
            state    <= uart_pkg::SPL_WAIT_LO;
          end
        end
        uart_pkg::SPL_WAIT_LO: begin
          if (!byte_ack) begin
            cmd_rdy <= 1'b1;
            state   <= uart_pkg::SPL_IDLE;
          end
        end
        default: state <= uart_pkg::SPL_IDLE;
      endcase
    end
  end

endmodule

// File: verilog/uart_pkg.sv
package uart_pkg;

  localparam int CMD_WIDTH  = 16;
  localparam int READ_WIDTH = 8;
  localparam int CLK_HZ     = 50_000_000;
  localparam int BAUD       = 3_125_000;
  localparam int BAUD_DIV   = CLK_HZ / BAUD;  // 16 clocks per bit
  localparam int HALF_DIV   = BAUD_DIV / 2;   // mid-bit
  localparam int FRAME_BITS = 11;             // start, 8 data, parity, stop

  localparam int BAUD_CNT_W = $clog2(BAUD_DIV);
  localparam int BIT_CNT_W  = $clog2(FRAME_BITS + 1);

  //////////////////////////////////////////////////////////////////////
  // state codes

  localparam logic [2:0] SPL_IDLE    = 3'd0;
  localparam logic [2:0] SPL_SEND_HI = 3'd1;
  localparam logic [2:0] SPL_WAIT_HI = 3'd2;
  localparam logic [2:0] SPL_SEND_LO = 3'd3;
  localparam logic [2:0] SPL_WAIT_LO = 3'd4;

  localparam logic [1:0] TX_IDLE = 2'd0;
  localparam logic [1:0] TX_LOAD = 2'd1;
  localparam logic [1:0] TX_SEND = 2'd2;
  localparam logic [1:0] TX_HOLD = 2'd3;  // frame done, req still up

  localparam logic [1:0] RX_IDLE  = 2'd0;
  localparam logic [1:0] RX_START = 2'd1;
  localparam logic [1:0] RX_DATA  = 2'd2;

  // host word, or the two bytes sent on the line
  typedef union packed {
    logic [CMD_WIDTH-1:0] raw;
    struct packed {
      logic [READ_WIDTH-1:0] hi;
      logic [READ_WIDTH-1:0] lo;
    } bytes;
  } cmd_word_u;

endpackage
